// ==== logic/tank_pkg.sv ====
/* tank arena package
   shared coordinate, state and interface types for the two-tank engine */
`default_nettype none

package tank_pkg;

    localparam int NUM_TANKS = 2;

    typedef logic [9:0] coord_t;      // screen pixel coordinate

    typedef enum logic [1:0] {
        DIR_DOWN  = 2'd0,
        DIR_UP    = 2'd1,
        DIR_RIGHT = 2'd2,
        DIR_LEFT  = 2'd3
    } dir_t;

    typedef enum logic [1:0] {
        B_IDLE = 2'd0,                // riding on the tank
        B_FLY  = 2'd1,
        B_HIT  = 2'd2                 // one cycle before rearm
    } bullet_state_t;

    typedef enum logic [1:0] {
        PK_NONE   = 2'd0,
        PK_TANK   = 2'd1,
        PK_BULLET = 2'd2
    } pixel_kind_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pos_t;

    typedef struct packed {
        logic move_valid;
        dir_t move_dir;
        logic fire_pulse;
    } tank_cmd_t;

    typedef struct packed {
        logic box;                    // pixel inside tank body
        logic bullet_px;              // pixel on live bullet
        pos_t bullet_pos;
    } tank_view_t;

    typedef struct packed {
        logic obstacle;
        logic bullet_stop;
        logic dead;
    } tank_fb_t;

    ////////////////////////////////
    // geometry, relative to the tank's upper left corner
    localparam coord_t TANK_LO     = 10'd3;
    localparam coord_t TANK_HI     = 10'd28;
    localparam coord_t TANK_SIZE   = 10'd32;
    localparam coord_t BULLET_SIZE = 10'd4;
    localparam coord_t BULLET_MID  = 10'd14;

endpackage

`default_nettype wire

// ==== logic/control_decoder.sv ====
/* control decoder
   turns one-hot move buttons into commands and fire levels into pulses */
`timescale 1ns/1ps
`default_nettype none

module control_decoder #(
    parameter int NUM_TANKS = 2
) (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic [4*NUM_TANKS-1:0]     move_i,
    input  logic [NUM_TANKS-1:0]       fire_i,
    output tank_pkg::tank_cmd_t        cmd_o [NUM_TANKS]
);

    logic [NUM_TANKS-1:0] fire_prev;
    logic [NUM_TANKS-1:0] fire_pulse;

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            fire_prev  <= '0;
            fire_pulse <= '0;
        end else begin
            fire_prev  <= fire_i;
            fire_pulse <= fire_i & ~fire_prev;  // rising edge, one cycle late
        end
    end

    always_comb begin
        for (int k = 0; k < NUM_TANKS; k++) begin
            cmd_o[k].fire_pulse = fire_pulse[k];
            cmd_o[k].move_valid = 1'b1;
            cmd_o[k].move_dir   = tank_pkg::DIR_DOWN;
            case (move_i[4*k +: 4])
                4'b0001: cmd_o[k].move_dir = tank_pkg::DIR_DOWN;
                4'b0010: cmd_o[k].move_dir = tank_pkg::DIR_UP;
                4'b0100: cmd_o[k].move_dir = tank_pkg::DIR_RIGHT;
                4'b1000: cmd_o[k].move_dir = tank_pkg::DIR_LEFT;
                default: cmd_o[k].move_valid = 1'b0;  // none or several pressed
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/bullet_unit.sv ====
/* bullet unit
   one bullet: spawn at the tank muzzle, flight on ticks, stop and rearm */
`timescale 1ns/1ps
`default_nettype none

module bullet_unit #(
    parameter int BULLET_STEP = 4
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              tick_i,
    input  logic              fire_i,
    input  logic              stop_i,
    input  tank_pkg::pos_t    tank_pos_i,
    input  tank_pkg::dir_t    facing_i,
    input  tank_pkg::coord_t  hpos_i,
    input  tank_pkg::coord_t  vpos_i,
    output logic              active_o,
    output logic              bullet_px_o,
    output tank_pkg::pos_t    bullet_pos_o
);

    localparam tank_pkg::coord_t STEP = tank_pkg::coord_t'(BULLET_STEP);

    tank_pkg::bullet_state_t state;
    tank_pkg::dir_t          fly_dir;
    tank_pkg::pos_t          pos;
    tank_pkg::pos_t          spawn;
    tank_pkg::coord_t        dx;
    tank_pkg::coord_t        dy;

    always_comb begin
        spawn.x = tank_pos_i.x + tank_pkg::BULLET_MID;
        spawn.y = tank_pos_i.y + tank_pkg::BULLET_MID;
        case (facing_i)
            tank_pkg::DIR_DOWN:  spawn.y = tank_pos_i.y + tank_pkg::TANK_SIZE;
            tank_pkg::DIR_UP:    spawn.y = tank_pos_i.y - tank_pkg::BULLET_SIZE;
            tank_pkg::DIR_RIGHT: spawn.x = tank_pos_i.x + tank_pkg::TANK_SIZE;
            default:             spawn.x = tank_pos_i.x - tank_pkg::BULLET_SIZE;
        endcase
    end

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            state <= tank_pkg::B_IDLE;
        end else begin
            case (state)
                tank_pkg::B_IDLE: if (fire_i) state <= tank_pkg::B_FLY;
                tank_pkg::B_FLY:  if (stop_i) state <= tank_pkg::B_HIT;
                default:          state <= tank_pkg::B_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == tank_pkg::B_IDLE) begin
            pos     <= spawn;      // follow the muzzle
            fly_dir <= facing_i;
        end else if (state == tank_pkg::B_FLY && tick_i && !stop_i) begin
            case (fly_dir)
                tank_pkg::DIR_DOWN:  pos.y <= pos.y + STEP;
                tank_pkg::DIR_UP:    pos.y <= pos.y - STEP;
                tank_pkg::DIR_RIGHT: pos.x <= pos.x + STEP;
                default:             pos.x <= pos.x - STEP;
            endcase
        end
    end

    assign dx = hpos_i - pos.x;  // wraps when left of the bullet
    assign dy = vpos_i - pos.y;

    assign active_o     = (state == tank_pkg::B_FLY);
    assign bullet_px_o  = active_o && (dx <= tank_pkg::BULLET_SIZE)
                          && (dy <= tank_pkg::BULLET_SIZE);
    assign bullet_pos_o = pos;

endmodule

`default_nettype wire

// ==== logic/tank_unit.sv ====
/* tank unit
   position, facing and side blocking of one tank, plus its bullet */
`timescale 1ns/1ps
`default_nettype none

module tank_unit #(
    parameter tank_pkg::coord_t START_X     = 10'd224,
    parameter tank_pkg::coord_t START_Y     = 10'd32,
    parameter tank_pkg::dir_t   START_DIR   = tank_pkg::DIR_DOWN,
    parameter int               MOVE_STEP   = 1,
    parameter int               BULLET_STEP = 4
) (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 tick_i,
    input  tank_pkg::tank_cmd_t  cmd_i,
    input  tank_pkg::tank_fb_t   fb_i,
    input  tank_pkg::coord_t     hpos_i,
    input  tank_pkg::coord_t     vpos_i,
    output tank_pkg::tank_view_t view_o,
    output tank_pkg::pos_t       pos_o,
    output logic                 bullet_active_o
);

    localparam tank_pkg::coord_t STEP      = tank_pkg::coord_t'(MOVE_STEP);
    localparam tank_pkg::coord_t EDGE_NEAR = tank_pkg::TANK_LO - 10'd1;
    localparam tank_pkg::coord_t EDGE_FAR  = tank_pkg::TANK_HI + 10'd1;
    localparam tank_pkg::coord_t SPAN_LO   = tank_pkg::TANK_LO + 10'd1;
    localparam tank_pkg::coord_t SPAN_HI   = tank_pkg::TANK_HI - 10'd1;

    tank_pkg::pos_t   pos;
    tank_pkg::dir_t   facing;
    tank_pkg::coord_t dx;
    tank_pkg::coord_t dy;
    tank_pkg::pos_t   bullet_pos;
    logic [3:0]       blocked;      // indexed by dir_t
    logic [3:0]       edge_hit;
    logic [3:0]       keep;
    logic             span_x;
    logic             span_y;
    logic             box;
    logic             bullet_px;

    ////////////////////////////////
    // raster tests against the body
    assign dx     = hpos_i - pos.x;
    assign dy     = vpos_i - pos.y;
    assign span_x = (dx >= SPAN_LO) && (dx <= SPAN_HI);
    assign span_y = (dy >= SPAN_LO) && (dy <= SPAN_HI);

    assign edge_hit[tank_pkg::DIR_DOWN]  = (dy == EDGE_FAR) && span_x;
    assign edge_hit[tank_pkg::DIR_UP]    = (dy == EDGE_NEAR) && span_x;
    assign edge_hit[tank_pkg::DIR_RIGHT] = (dx == EDGE_FAR) && span_y;
    assign edge_hit[tank_pkg::DIR_LEFT]  = (dx == EDGE_NEAR) && span_y;

    assign box = !fb_i.dead
                 && (dx >= tank_pkg::TANK_LO) && (dx <= tank_pkg::TANK_HI)
                 && (dy >= tank_pkg::TANK_LO) && (dy <= tank_pkg::TANK_HI);

    // a move forgets the other three sides
    assign keep = cmd_i.move_valid ? (4'b0001 << cmd_i.move_dir) : 4'b1111;

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            blocked <= '0;
        end else begin
            blocked <= (blocked & keep) | (fb_i.obstacle ? edge_hit : 4'b0000);
        end
    end

    ////////////////////////////////
    // movement on the tick strobe
    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            pos.x  <= START_X;
            pos.y  <= START_Y;
            facing <= START_DIR;
        end else if (tick_i && cmd_i.move_valid && !blocked[cmd_i.move_dir]) begin
            facing <= cmd_i.move_dir;
            case (cmd_i.move_dir)
                tank_pkg::DIR_DOWN:  pos.y <= pos.y + STEP;
                tank_pkg::DIR_UP:    pos.y <= pos.y - STEP;
                tank_pkg::DIR_RIGHT: pos.x <= pos.x + STEP;
                default:             pos.x <= pos.x - STEP;
            endcase
        end
    end

    bullet_unit #(
        .BULLET_STEP (BULLET_STEP)
    ) u_bullet_unit (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .tick_i       (tick_i),
        .fire_i       (cmd_i.fire_pulse),
        .stop_i       (fb_i.bullet_stop),
        .tank_pos_i   (pos),
        .facing_i     (facing),
        .hpos_i       (hpos_i),
        .vpos_i       (vpos_i),
        .active_o     (bullet_active_o),
        .bullet_px_o  (bullet_px),
        .bullet_pos_o (bullet_pos)
    );

    assign view_o = '{box: box, bullet_px: bullet_px, bullet_pos: bullet_pos};
    assign pos_o  = pos;

endmodule

`default_nettype wire

// ==== logic/arena_resolver.sv ====
/* arena resolver
   tank-to-tank interactions, sticky hit latches and pixel classification */
`timescale 1ns/1ps
`default_nettype none

module arena_resolver #(
    parameter int NUM_TANKS = 2
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  tank_pkg::tank_view_t  view_i [NUM_TANKS],
    input  logic                  cannot_walk_i,
    input  logic                  hard_block_i,
    input  logic                  destroyable_i,
    output tank_pkg::tank_fb_t    fb_o [NUM_TANKS],
    output logic [NUM_TANKS-1:0]  hit_o,
    output tank_pkg::pixel_kind_t pixel_kind_o,
    output logic                  brick_hit_o
);

    logic [NUM_TANKS-1:0] box;
    logic [NUM_TANKS-1:0] bullet_px;
    logic [NUM_TANKS-1:0] hit_now;  // tank k struck this cycle

    always_comb begin
        for (int k = 0; k < NUM_TANKS; k++) begin
            box[k]       = view_i[k].box;
            bullet_px[k] = view_i[k].bullet_px;
            hit_now[k]   = bullet_px[(k + 1) % NUM_TANKS] && box[k];
        end
    end

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            hit_o <= '0;
        end else begin
            hit_o <= hit_o | hit_now;  // sticky until reset
        end
    end

    always_comb begin
        for (int k = 0; k < NUM_TANKS; k++) begin
            fb_o[k].obstacle    = cannot_walk_i || box[(k + 1) % NUM_TANKS];
            fb_o[k].bullet_stop = (bullet_px[k]
                                   && (hard_block_i || bullet_px[(k + 1) % NUM_TANKS]))
                                  || hit_now[(k + 1) % NUM_TANKS];
            fb_o[k].dead        = hit_o[k];
        end
    end

    ////////////////////////////////
    // what the raster is showing
    always_comb begin
        if (|bullet_px)  pixel_kind_o = tank_pkg::PK_BULLET;  // bullets on top
        else if (|box)   pixel_kind_o = tank_pkg::PK_TANK;
        else             pixel_kind_o = tank_pkg::PK_NONE;
    end

    assign brick_hit_o = destroyable_i && (|bullet_px);

endmodule

`default_nettype wire

// ==== logic/tank_arena.sv ====
/* tank arena top
   button decode, two tank units and the resolver between them */
`timescale 1ns/1ps
`default_nettype none

module tank_arena #(
    parameter int MOVE_STEP   = 1,
    parameter int BULLET_STEP = 4
) (
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  logic                            tick_i,
    input  logic [4*tank_pkg::NUM_TANKS-1:0] move_i,
    input  logic [tank_pkg::NUM_TANKS-1:0]  fire_i,
    input  tank_pkg::coord_t                hpos_i,
    input  tank_pkg::coord_t                vpos_i,
    input  logic                            cannot_walk_i,
    input  logic                            hard_block_i,
    input  logic                            destroyable_i,
    output tank_pkg::pos_t                  tank_pos_o [tank_pkg::NUM_TANKS],
    output tank_pkg::pos_t                  bullet_pos_o [tank_pkg::NUM_TANKS],
    output logic [tank_pkg::NUM_TANKS-1:0]  bullet_active_o,
    output logic [tank_pkg::NUM_TANKS-1:0]  hit_o,
    output tank_pkg::pixel_kind_t           pixel_kind_o,
    output logic                            brick_hit_o
);

    tank_pkg::tank_cmd_t  cmd  [tank_pkg::NUM_TANKS];
    tank_pkg::tank_view_t view [tank_pkg::NUM_TANKS];
    tank_pkg::tank_fb_t   fb   [tank_pkg::NUM_TANKS];

    control_decoder #(
        .NUM_TANKS (tank_pkg::NUM_TANKS)
    ) u_control_decoder (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .move_i  (move_i),
        .fire_i  (fire_i),
        .cmd_o   (cmd)
    );

    generate
        for (genvar i = 0; i < tank_pkg::NUM_TANKS; i++) begin : g_tank
            localparam tank_pkg::coord_t START_X = 10'd224;  // tile column 7
            localparam tank_pkg::coord_t START_Y = (i == 0) ? 10'd32 : 10'd416;
            localparam tank_pkg::dir_t START_DIR =
                (i == 0) ? tank_pkg::DIR_DOWN : tank_pkg::DIR_UP;  // face each other

            tank_unit #(
                .START_X     (START_X),
                .START_Y     (START_Y),
                .START_DIR   (START_DIR),
                .MOVE_STEP   (MOVE_STEP),
                .BULLET_STEP (BULLET_STEP)
            ) u_tank_unit (
                .clk_i           (clk_i),
                .reset_i         (reset_i),
                .tick_i          (tick_i),
                .cmd_i           (cmd[i]),
                .fb_i            (fb[i]),
                .hpos_i          (hpos_i),
                .vpos_i          (vpos_i),
                .view_o          (view[i]),
                .pos_o           (tank_pos_o[i]),
                .bullet_active_o (bullet_active_o[i])
            );

            assign bullet_pos_o[i] = view[i].bullet_pos;
        end
    endgenerate

    arena_resolver #(
        .NUM_TANKS (tank_pkg::NUM_TANKS)
    ) u_arena_resolver (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .view_i        (view),
        .cannot_walk_i (cannot_walk_i),
        .hard_block_i  (hard_block_i),
        .destroyable_i (destroyable_i),
        .fb_o          (fb),
        .hit_o         (hit_o),
        .pixel_kind_o  (pixel_kind_o),
        .brick_hit_o   (brick_hit_o)
    );

endmodule

`default_nettype wire

// ==== verif/tank_arena_scoreboard.sv ====
/* tank arena scoreboard
   compares DUT outputs with the expected values of each command line */
`timescale 1ns/1ps
`default_nettype none

module tank_arena_scoreboard (
    input  logic                  clk_i,
    input  logic                  check_i,
    input  logic                  pixel_chk_i,
    input  logic                  bpos_chk_i,
    input  logic                  bpos_sel_i,
    input  int                    test_id_i,
    input  tank_pkg::pos_t        exp_pos_i [tank_pkg::NUM_TANKS],
    input  tank_pkg::pos_t        exp_bpos_i,
    input  logic [1:0]            exp_active_i,
    input  logic [1:0]            exp_hit_i,
    input  logic                  exp_brick_i,
    input  tank_pkg::pixel_kind_t exp_kind_i,
    input  tank_pkg::pos_t        tank_pos_i [tank_pkg::NUM_TANKS],
    input  tank_pkg::pos_t        bullet_pos_i [tank_pkg::NUM_TANKS],
    input  logic [1:0]            bullet_active_i,
    input  logic [1:0]            hit_i,
    input  logic                  brick_hit_i,
    input  tank_pkg::pixel_kind_t pixel_kind_i,
    output int                    pass_cnt_o,
    output int                    fail_cnt_o
);

    int errs = 0;
    int passes = 0;
    int fails = 0;

    task automatic compare(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
            errs++;
        end
    endtask

    always @(posedge clk_i) begin
        if (pixel_chk_i) begin
            compare("brick_hit_o", int'(brick_hit_i), int'(exp_brick_i));
            compare("pixel_kind_o", int'(pixel_kind_i), int'(exp_kind_i));
        end
        if (check_i) begin
            for (int k = 0; k < tank_pkg::NUM_TANKS; k++) begin
                compare($sformatf("tank_pos_o[%0d].x", k),
                        int'(tank_pos_i[k].x), int'(exp_pos_i[k].x));
                compare($sformatf("tank_pos_o[%0d].y", k),
                        int'(tank_pos_i[k].y), int'(exp_pos_i[k].y));
            end
            if (bpos_chk_i) begin
                compare("bullet_pos_o.x", int'(bullet_pos_i[bpos_sel_i].x),
                        int'(exp_bpos_i.x));
                compare("bullet_pos_o.y", int'(bullet_pos_i[bpos_sel_i].y),
                        int'(exp_bpos_i.y));
            end
            compare("bullet_active_o", int'(bullet_active_i), int'(exp_active_i));
            compare("hit_o", int'(hit_i), int'(exp_hit_i));
            if (errs == 0) begin
                passes++;
                $display("test %0d passed", test_id_i);
            end else begin
                fails++;
                $display("test %0d failed with %0d mismatches", test_id_i, errs);
            end
            errs = 0;
        end
    end

    assign pass_cnt_o = passes;
    assign fail_cnt_o = fails;

endmodule

`default_nettype wire

// ==== verif/tank_arena_checker.sv ====
/* tank arena checker
   sticky hit latches and the one-cycle bullet hit state */
`timescale 1ns/1ps
`default_nettype none

module tank_arena_checker (
    input logic                    clk_i,
    input logic                    reset_i,
    input logic [1:0]              hit_i,
    input tank_pkg::bullet_state_t state0_i,
    input tank_pkg::bullet_state_t state1_i
);

    hit_sticky: assert property (@(posedge clk_i) disable iff (reset_i)
        (hit_i & $past(hit_i)) == $past(hit_i))
        else $error("hit latch fell without reset");

    hit_to_idle0: assert property (@(posedge clk_i) disable iff (reset_i)
        state0_i == tank_pkg::B_HIT |=> state0_i == tank_pkg::B_IDLE)
        else $error("bullet 0 stayed out of idle after a hit");

    hit_to_idle1: assert property (@(posedge clk_i) disable iff (reset_i)
        state1_i == tank_pkg::B_HIT |=> state1_i == tank_pkg::B_IDLE)
        else $error("bullet 1 stayed out of idle after a hit");

endmodule

bind tank_arena tank_arena_checker u_tank_arena_checker (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .hit_i    (hit_o),
    .state0_i (g_tank[0].u_tank_unit.u_bullet_unit.state),
    .state1_i (g_tank[1].u_tank_unit.u_bullet_unit.state)
);

`default_nettype wire

// ==== verif/tank_arena_tb.sv ====
/* tank arena testbench
   file-driven commands, pixels and ticks against the two-tank engine */
`timescale 1ns/1ps
`default_nettype none

module tank_arena_tb;

    localparam int NT = tank_pkg::NUM_TANKS;

    logic                    clk_i;
    logic                    reset_i;
    logic                    tick_i;
    logic [4*NT-1:0]         move_i;
    logic [NT-1:0]           fire_i;
    tank_pkg::coord_t        hpos_i;
    tank_pkg::coord_t        vpos_i;
    logic                    cannot_walk_i;
    logic                    hard_block_i;
    logic                    destroyable_i;
    tank_pkg::pos_t          tank_pos_o [NT];
    tank_pkg::pos_t          bullet_pos_o [NT];
    logic [NT-1:0]           bullet_active_o;
    logic [NT-1:0]           hit_o;
    tank_pkg::pixel_kind_t   pixel_kind_o;
    logic                    brick_hit_o;

    tank_pkg::pos_t          exp_pos [NT];
    tank_pkg::pos_t          exp_bpos;
    logic [NT-1:0]           exp_active;
    logic [NT-1:0]           exp_hit;
    logic                    exp_brick;
    tank_pkg::pixel_kind_t   exp_kind;
    tank_pkg::pos_t          fired_pos [NT];   // launch point of the last shot
    logic [NT-1:0]           last_active;
    logic [NT-1:0]           last_hit;
    logic                    check_req;
    logic                    pixel_req;
    logic                    bpos_req;
    logic                    bpos_sel;
    int                      test_id;
    int                      tb_errors;
    int                      pass_cnt;
    int                      fail_cnt;

    tank_arena #(
        .MOVE_STEP   (1),
        .BULLET_STEP (4)
    ) u_tank_arena (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .tick_i          (tick_i),
        .move_i          (move_i),
        .fire_i          (fire_i),
        .hpos_i          (hpos_i),
        .vpos_i          (vpos_i),
        .cannot_walk_i   (cannot_walk_i),
        .hard_block_i    (hard_block_i),
        .destroyable_i   (destroyable_i),
        .tank_pos_o      (tank_pos_o),
        .bullet_pos_o    (bullet_pos_o),
        .bullet_active_o (bullet_active_o),
        .hit_o           (hit_o),
        .pixel_kind_o    (pixel_kind_o),
        .brick_hit_o     (brick_hit_o)
    );

    tank_arena_scoreboard u_scoreboard (
        .clk_i           (clk_i),
        .check_i         (check_req),
        .pixel_chk_i     (pixel_req),
        .bpos_chk_i      (bpos_req),
        .bpos_sel_i      (bpos_sel),
        .test_id_i       (test_id),
        .exp_pos_i       (exp_pos),
        .exp_bpos_i      (exp_bpos),
        .exp_active_i    (exp_active),
        .exp_hit_i       (exp_hit),
        .exp_brick_i     (exp_brick),
        .exp_kind_i      (exp_kind),
        .tank_pos_i      (tank_pos_o),
        .bullet_pos_i    (bullet_pos_o),
        .bullet_active_i (bullet_active_o),
        .hit_i           (hit_o),
        .brick_hit_i     (brick_hit_o),
        .pixel_kind_i    (pixel_kind_o),
        .pass_cnt_o      (pass_cnt),
        .fail_cnt_o      (fail_cnt)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    initial begin
        #2_000_000;
        $display("simulation ran past its time limit");
        $display("TB FAILED");
        $finish;
    end

    // bullets above live tank bodies above background
    function automatic tank_pkg::pixel_kind_t expected_kind(input int h, input int v);
        int ox;
        int oy;
        expected_kind = tank_pkg::PK_NONE;
        for (int k = 0; k < NT; k++) begin
            ox = h - int'(exp_pos[k].x);
            oy = v - int'(exp_pos[k].y);
            if (!last_hit[k] && ox >= int'(tank_pkg::TANK_LO) && ox <= int'(tank_pkg::TANK_HI)
                && oy >= int'(tank_pkg::TANK_LO) && oy <= int'(tank_pkg::TANK_HI))
                expected_kind = tank_pkg::PK_TANK;
        end
        for (int k = 0; k < NT; k++) begin
            ox = h - int'(fired_pos[k].x);
            oy = v - int'(fired_pos[k].y);
            if (last_active[k] && ox >= 0 && ox <= int'(tank_pkg::BULLET_SIZE)
                && oy >= 0 && oy <= int'(tank_pkg::BULLET_SIZE))
                expected_kind = tank_pkg::PK_BULLET;
        end
    endfunction

    ////////////////////////////////
    // stimulus tasks
    task automatic idle(input int n);
        repeat (n) @(posedge clk_i);
    endtask

    task automatic drive_move(input int plr, input int dir, input int cnt);
        @(posedge clk_i);
        move_i <= (4*NT)'(4'b0001 << dir) << (4*plr);
        tick_i <= (cnt != 0);
        repeat ((cnt != 0) ? cnt : 3) @(posedge clk_i);  // zero ticks holds 3 cycles
        move_i <= '0;
        tick_i <= 1'b0;
    endtask

    task automatic drive_pixel(input int h, input int v, input int flg);
        @(posedge clk_i);
        hpos_i        <= 10'(h);
        vpos_i        <= 10'(v);
        cannot_walk_i <= flg[0];
        hard_block_i  <= flg[1];
        destroyable_i <= flg[2];
        exp_kind      <= expected_kind(h, v);
        pixel_req     <= 1'b1;
        @(posedge clk_i);
        hpos_i        <= '0;
        vpos_i        <= '0;
        cannot_walk_i <= 1'b0;
        hard_block_i  <= 1'b0;
        destroyable_i <= 1'b0;
        pixel_req     <= 1'b0;
        idle(1);                       // a hard stop must show by the check
    endtask

    task automatic probe_pixel(input int h, input int v, input tank_pkg::pixel_kind_t kind);
        @(posedge clk_i);
        hpos_i    <= 10'(h);
        vpos_i    <= 10'(v);
        exp_kind  <= kind;
        pixel_req <= 1'b1;
        @(posedge clk_i);
        hpos_i    <= '0;
        vpos_i    <= '0;
        pixel_req <= 1'b0;
    endtask

    task automatic drive_fire(input int plr);
        int i;
        @(posedge clk_i);
        fire_i <= '0;                  // let a held button rise again
        @(posedge clk_i);
        fire_i <= NT'(1 << plr);
        for (i = 0; i < 8 && !bullet_active_o[plr]; i++) @(posedge clk_i);
        if (!bullet_active_o[plr]) begin
            $display("bullet of tank %0d did not launch after fire", plr);
            tb_errors++;
        end
        idle(4);                       // button stays held until the next fire
    endtask

    task automatic fly_until_hit(input int plr, input int tx, input int ty);
        int              i;
        logic            struck;
        tank_pkg::pos_t  bp;
        struck = 1'b0;
        probe_pixel(tx + 16, ty + 16, tank_pkg::PK_TANK);  // target body while alive
        for (i = 0; i < 150 && !struck; i++) begin
            @(posedge clk_i);
            tick_i <= 1'b1;
            hpos_i <= '0;
            vpos_i <= '0;
            @(posedge clk_i);
            tick_i <= 1'b0;
            @(negedge clk_i);
            bp     = bullet_pos_o[plr];
            struck = hit_o[1 - plr];
            @(posedge clk_i);
            hpos_i <= bp.x;             // look at the bullet
            vpos_i <= bp.y;
        end
        @(posedge clk_i);
        hpos_i <= '0;
        vpos_i <= '0;
        if (!struck) begin
            $display("bullet of tank %0d never hit the other tank", plr);
            tb_errors++;
        end
        probe_pixel(tx + 16, ty + 16, tank_pkg::PK_NONE);  // dead body no longer a tank
        idle(3);
    endtask

    ////////////////////////////////
    // command file loop
    initial begin
        int    fd;
        int    rc;
        string line;
        int    op, plr, dir, cnt, hx, vy, flg;
        int    e0x, e0y, e1x, e1y, ebx, eby, eba, ehit, ebr;
        reset_i = 1'b1;
        tick_i = 1'b0;
        move_i = '0;
        fire_i = '0;
        hpos_i = '0;
        vpos_i = '0;
        cannot_walk_i = 1'b0;
        hard_block_i = 1'b0;
        destroyable_i = 1'b0;
        check_req = 1'b0;
        pixel_req = 1'b0;
        bpos_req = 1'b0;
        bpos_sel = 1'b0;
        exp_brick = 1'b0;
        exp_kind = tank_pkg::PK_NONE;
        fired_pos[0] = '0;
        fired_pos[1] = '0;
        last_active = '0;
        last_hit = '0;
        test_id = 0;
        tb_errors = 0;
        repeat (10) @(posedge clk_i);
        reset_i <= 1'b0;
        fd = $fopen("verif/arena_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the command file");
            tb_errors++;
        end else begin
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                if (rc == 0 || line.len() < 2 || line.getc(0) == 8'h23) continue;
                rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                             op, plr, dir, cnt, hx, vy, flg, e0x, e0y, e1x, e1y,
                             ebx, eby, eba, ehit, ebr);
                if (rc != 16) begin
                    $display("malformed command line: %s", line);
                    tb_errors++;
                    continue;
                end
                exp_pos[0] <= '{x: 10'(e0x), y: 10'(e0y)};
                exp_pos[1] <= '{x: 10'(e1x), y: 10'(e1y)};
                exp_bpos   <= '{x: 10'(ebx), y: 10'(eby)};
                exp_active <= NT'(eba);
                exp_hit    <= NT'(ehit);
                exp_brick  <= ebr[0];
                bpos_sel   <= plr[0];
                bpos_req   <= (op == 3);
                case (op)
                    1:       drive_move(plr, dir, cnt);
                    2:       drive_pixel(hx, vy, flg);
                    3:       drive_fire(plr);
                    4:       fly_until_hit(plr, (plr == 0) ? e1x : e0x,
                                           (plr == 0) ? e1y : e0y);
                    default: idle(2);
                endcase
                @(posedge clk_i);
                check_req <= 1'b1;
                @(posedge clk_i);
                check_req <= 1'b0;
                test_id   <= test_id + 1;
                if (op == 3) fired_pos[plr] = '{x: 10'(ebx), y: 10'(eby)};
                last_active = NT'(eba);
                last_hit    = NT'(ehit);
            end
            $fclose(fd);
        end
        idle(2);
        $display("tests passed %0d, failed %0d, testbench errors %0d",
                 pass_cnt, fail_cnt, tb_errors);
        if (fail_cnt == 0 && tb_errors == 0 && pass_cnt > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/arena_input.txt ====
# op(0 chk 1 move 2 pixel 3 fire 4 fly) plr dir ticks hpos vpos flags(1 walk 2 hard 4 brick)
# then expected: t0x t0y t1x t1y bullet_x bullet_y bullet_active hit brick_hit (all hex)
0 0 0 0 000 000 0 0e0 020 0e0 1a0 000 000 0 0 0
1 0 0 5 000 000 0 0e0 025 0e0 1a0 000 000 0 0 0
1 0 0 0 000 000 0 0e0 025 0e0 1a0 000 000 0 0 0
1 0 1 5 000 000 0 0e0 020 0e0 1a0 000 000 0 0 0
2 0 0 0 0e6 022 1 0e0 020 0e0 1a0 000 000 0 0 0
1 0 1 3 000 000 0 0e0 020 0e0 1a0 000 000 0 0 0
1 0 0 2 000 000 0 0e0 022 0e0 1a0 000 000 0 0 0
1 0 1 1 000 000 0 0e0 021 0e0 1a0 000 000 0 0 0
3 0 0 0 000 000 0 0e0 021 0e0 1a0 0ee 01d 1 0 0
2 0 0 0 0ee 01d 4 0e0 021 0e0 1a0 000 000 1 0 1
2 0 0 0 0ee 01d 2 0e0 021 0e0 1a0 000 000 0 0 0
1 0 0 1 000 000 0 0e0 022 0e0 1a0 000 000 0 0 0
3 0 0 0 000 000 0 0e0 022 0e0 1a0 0ee 042 1 0 0
4 0 0 0 000 000 0 0e0 022 0e0 1a0 000 000 0 2 0
1 0 0 3 000 000 0 0e0 025 0e0 1a0 000 000 0 2 0

// ==== project.f ====
logic/tank_pkg.sv
logic/control_decoder.sv
logic/bullet_unit.sv
logic/tank_unit.sv
logic/arena_resolver.sv
logic/tank_arena.sv
verif/tank_arena_scoreboard.sv
verif/tank_arena_checker.sv
verif/tank_arena_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tank_arena_tb
FILELIST  ?= project.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o sim
	./obj_dir/sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then exit 1; fi
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
